//--- Makefile
SIM := obj_dir/Vps2_tb
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

$(SIM): ps2_port.f $(SRCS)
	verilator --binary --assert --top-module ps2_tb -f ps2_port.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- ps2_bus_regs.sv
// PS/2 port bus registers
module ps2_bus_regs (
	input  logic        clk,
	input  logic        reset,
	input  logic        cs_i,
	input  logic        we_i,
	input  logic        addr_i,
	input  logic [3:0]  be_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata_o,
	output logic        ready_o,
	output logic        irq_o,
	ps2_rdq_if.reader   q,
	ps2_cmd_if.host     cmd
);

	ps2_pkg::reg_sel_t sel;
	logic        data_rd;
	logic        cmd_wr;
	logic        re_wr;
	logic        ce_clr;
	logic        cmd_done;
	logic        req_q;
	logic [7:0]  cmd_q;
	logic        re_q;
	logic        ri_q;
	logic        ce_q;
	logic [31:0] data_word;
	logic [31:0] ctrl_word;

	assign sel = ps2_pkg::reg_sel_t'(addr_i);

	// Access decode
	assign data_rd = cs_i & ~we_i & (sel == ps2_pkg::REG_DATA) & be_i[0];
	assign cmd_wr  = cs_i & we_i & (sel == ps2_pkg::REG_DATA) & be_i[0];
	assign re_wr   = cs_i & we_i & (sel == ps2_pkg::REG_CTRL) & be_i[0];
	assign ce_clr  = cs_i & we_i & (sel == ps2_pkg::REG_CTRL) & be_i[1];

	// Pop on data read, the head is returned before it moves
	assign q.pop = data_rd;

	// Only our own ack ends a command access
	assign cmd_done = req_q & cmd.ack;
	// Stall a command write until the engine answers
	assign ready_o  = ~(cmd_wr & ~cmd_done);

	assign cmd.req = req_q;
	assign cmd.cmd = cmd_q;
	assign irq_o   = ri_q;

	always_comb
	begin
		data_word = '0;
		data_word[ps2_pkg::DATA_COUNT_LSB +: 16] = 16'(q.count);
		data_word[ps2_pkg::DATA_VALID_BIT]       = ~q.empty;
		data_word[7:0]                           = q.data;
		ctrl_word = '0;
		ctrl_word[ps2_pkg::CTRL_RE_BIT] = re_q;
		ctrl_word[ps2_pkg::CTRL_RI_BIT] = ri_q;
		ctrl_word[ps2_pkg::CTRL_CE_BIT] = ce_q;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			req_q   <= 1'b0;
			re_q    <= 1'b0;
			ri_q    <= 1'b0;
			ce_q    <= 1'b0;
			rdata_o <= '0;
		end
		else
		begin
			// Read data captured on every access
			if (cs_i)
				rdata_o <= (sel == ps2_pkg::REG_DATA) ? data_word : ctrl_word;
			// Raise req once the previous ack has cleared
			if (cmd_wr && !req_q && !cmd.ack)
				req_q <= 1'b1;
			else if (cmd_done)
				req_q <= 1'b0;
			// Error set beats software clear
			if (cmd_done && cmd.err)
				ce_q <= 1'b1;
			else if (ce_clr)
				ce_q <= 1'b0;
			if (re_wr)
				re_q <= wdata_i[0];
			ri_q <= re_q & ~q.empty;
		end
	end

	// Command byte held for the whole transfer
	always_ff @(posedge clk)
	begin
		if (cmd_wr && !req_q && !cmd.ack)
			cmd_q <= wdata_i[7:0];
	end

endmodule

//--- ps2_cmd_tx.sv
// PS/2 host-to-device command engine
module ps2_cmd_tx #(
	parameter int INHIBIT_CYCLES = 10100,
	parameter int START_TIMEOUT  = 1500000,
	parameter int XFER_TIMEOUT   = 200000
) (
	input  logic   clk,
	input  logic   reset,
	ps2_cmd_if.engine cmd,
	input  logic   dev_clk_fall_i,
	input  logic   dev_dat_i,
	output logic   ps2_clk_oe_o,
	output logic   ps2_dat_oe_o,
	output logic   tx_busy_o
);

	// Shared counter sized for the longest interval
	localparam int MAX_T = (START_TIMEOUT > XFER_TIMEOUT) ?
		((START_TIMEOUT > INHIBIT_CYCLES) ? START_TIMEOUT : INHIBIT_CYCLES) :
		((XFER_TIMEOUT > INHIBIT_CYCLES) ? XFER_TIMEOUT : INHIBIT_CYCLES);
	localparam int CW = $clog2(MAX_T + 1);

	ps2_pkg::tx_state_t state;
	logic [CW-1:0]      cnt;
	logic [3:0]         bit_cnt;
	logic [9:0]         frame_q;
	logic               ack_q;
	logic               err_q;
	logic               start_cmd;
	logic               xfer_to;

	assign cmd.ack   = ack_q;
	assign cmd.err   = err_q;
	assign tx_busy_o = (state != ps2_pkg::TX_IDLE);

	// New request only once the previous ack has dropped
	assign start_cmd = (state == ps2_pkg::TX_IDLE) & cmd.req & ~ack_q;
	assign xfer_to   = (cnt == CW'(XFER_TIMEOUT - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state        <= ps2_pkg::TX_IDLE;
			cnt          <= '0;
			bit_cnt      <= '0;
			ack_q        <= 1'b0;
			err_q        <= 1'b0;
			ps2_clk_oe_o <= 1'b0;
			ps2_dat_oe_o <= 1'b0;
		end
		else
		begin
			cnt <= cnt + 1'b1;
			case (state)
			ps2_pkg::TX_IDLE:
			begin
				cnt <= '0;
				if (start_cmd)
				begin
					// Pull clock low to claim the bus
					err_q        <= 1'b0;
					ps2_clk_oe_o <= 1'b1;
					state        <= ps2_pkg::TX_INHIBIT;
				end
			end
			ps2_pkg::TX_INHIBIT:
				if (cnt == CW'(INHIBIT_CYCLES - 1))
				begin
					// Start bit low, clock released together
					cnt          <= '0;
					ps2_clk_oe_o <= 1'b0;
					ps2_dat_oe_o <= 1'b1;
					state        <= ps2_pkg::TX_START;
				end
			ps2_pkg::TX_START:
				if (dev_clk_fall_i)
				begin
					// First device clock, frame timer starts here
					cnt          <= '0;
					bit_cnt      <= 4'd1;
					ps2_dat_oe_o <= ~frame_q[0];
					state        <= ps2_pkg::TX_BITS;
				end
				else if (cnt == CW'(START_TIMEOUT - 1))
				begin
					err_q        <= 1'b1;
					ps2_dat_oe_o <= 1'b0;
					state        <= ps2_pkg::TX_DONE;
				end
			ps2_pkg::TX_BITS:
				if (xfer_to)
				begin
					err_q        <= 1'b1;
					ps2_dat_oe_o <= 1'b0;
					state        <= ps2_pkg::TX_DONE;
				end
				else if (dev_clk_fall_i)
				begin
					// Data, parity, then stop released high
					ps2_dat_oe_o <= ~frame_q[0];
					bit_cnt      <= bit_cnt + 4'd1;
					if (bit_cnt == 4'd9)
						state <= ps2_pkg::TX_ACKBIT;
				end
			ps2_pkg::TX_ACKBIT:
				if (xfer_to)
				begin
					err_q <= 1'b1;
					state <= ps2_pkg::TX_DONE;
				end
				else if (dev_clk_fall_i)
				begin
					// Device acknowledge must hold data low
					err_q <= dev_dat_i;
					state <= ps2_pkg::TX_DONE;
				end
			ps2_pkg::TX_DONE:
				// err settled, raise ack, then wait for req to drop
				if (!ack_q)
					ack_q <= 1'b1;
				else if (!cmd.req)
				begin
					ack_q <= 1'b0;
					state <= ps2_pkg::TX_IDLE;
				end
			default:
				state <= ps2_pkg::TX_IDLE;
			endcase
		end
	end

	// Stop, odd parity and data loaded at request time
	always_ff @(posedge clk)
	begin
		if (start_cmd)
			frame_q <= {1'b1, ~^cmd.cmd, cmd.cmd};
		else if (dev_clk_fall_i && (state == ps2_pkg::TX_START || state == ps2_pkg::TX_BITS))
			frame_q <= {1'b1, frame_q[9:1]};
	end

endmodule

//--- ps2_if.sv
// PS/2 host port
// Command handshake and receive queue interfaces

// Four-phase req/ack link to the command engine
interface ps2_cmd_if;
	logic       req;
	logic [7:0] cmd;
	logic       ack;
	logic       err;

	// Register block side
	modport host (output req, output cmd, input ack, input err);
	// Transmitter side
	modport engine (input req, input cmd, output ack, output err);
endinterface

// Showahead read port of the receive queue
interface ps2_rdq_if #(
	parameter int CNT_W = 5
);
	logic             pop;
	logic [7:0]       data;
	logic             empty;
	logic             full;
	logic [CNT_W-1:0] count;

	// Bus register side
	modport reader (output pop, input data, input empty, input full, input count);
	// Queue side
	modport queue (input pop, output data, output empty, output full, output count);
endinterface

//--- ps2_pkg.sv
// PS/2 host port
// Shared types and register fields
package ps2_pkg;

	// Word select from the single address bit
	typedef enum logic [0:0]
	{
		REG_DATA = 1'b0,
		REG_CTRL = 1'b1
	} reg_sel_t;

	// Command engine states
	typedef enum logic [2:0]
	{
		TX_IDLE    = 3'd0,
		TX_INHIBIT = 3'd1,
		TX_START   = 3'd2,
		TX_BITS    = 3'd3,
		TX_ACKBIT  = 3'd4,
		TX_DONE    = 3'd5
	} tx_state_t;

	// Control register fields
	// Receive interrupt enable
	localparam int CTRL_RE_BIT = 0;
	// Receive interrupt pending
	localparam int CTRL_RI_BIT = 8;
	// Sticky command error
	localparam int CTRL_CE_BIT = 10;

	// Data register fields
	// Head byte valid
	localparam int DATA_VALID_BIT = 15;
	// Queue occupancy, upper half word
	localparam int DATA_COUNT_LSB = 16;

endpackage

//--- ps2_port.f
ps2_pkg.sv
ps2_if.sv
ps2_rx.sv
ps2_cmd_tx.sv
ps2_rx_fifo.sv
ps2_bus_regs.sv
ps2_port.sv
ps2_props.sv
ps2_tb.sv

//--- ps2_port.sv
// PS/2 host port top level
module ps2_port #(
	parameter int CLK_FREQ   = 100_000_000,
	parameter int FIFO_DEPTH = 16
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        cs_i,
	input  logic        we_i,
	input  logic        addr_i,
	input  logic [3:0]  be_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rdata_o,
	output logic        ready_o,
	output logic        irq_o,
	input  logic        ps2_clk_i,
	input  logic        ps2_dat_i,
	output logic        ps2_clk_oe_o,
	output logic        ps2_dat_oe_o
);

	// Protocol times in clock cycles
	// 101 us clock inhibit
	localparam int INHIBIT_CYCLES = CLK_FREQ / 1000 * 101 / 1000;
	// 15 ms to the first device clock
	localparam int START_TIMEOUT  = CLK_FREQ / 200 * 3;
	// 2 ms for the whole frame
	localparam int XFER_TIMEOUT   = CLK_FREQ / 500;

	logic       dev_clk_fall;
	logic       dev_dat;
	logic       rx_push;
	logic [7:0] rx_byte;
	logic       tx_busy;

	ps2_cmd_if i_cmd_if ();
	ps2_rdq_if #(.CNT_W($clog2(FIFO_DEPTH) + 1)) i_rdq_if ();

	ps2_rx i_ps2_rx (
		.clk            (clk),
		.reset          (reset),
		.ps2_clk_i      (ps2_clk_i),
		.ps2_dat_i      (ps2_dat_i),
		.tx_busy_i      (tx_busy),
		.dev_clk_fall_o (dev_clk_fall),
		.dev_dat_o      (dev_dat),
		.push_o         (rx_push),
		.byte_o         (rx_byte)
	);

	ps2_rx_fifo #(.DEPTH(FIFO_DEPTH)) i_ps2_rx_fifo (
		.clk    (clk),
		.reset  (reset),
		.push_i (rx_push),
		.din_i  (rx_byte),
		.q      (i_rdq_if.queue)
	);

	ps2_cmd_tx #(
		.INHIBIT_CYCLES (INHIBIT_CYCLES),
		.START_TIMEOUT  (START_TIMEOUT),
		.XFER_TIMEOUT   (XFER_TIMEOUT)
	) i_ps2_cmd_tx (
		.clk            (clk),
		.reset          (reset),
		.cmd            (i_cmd_if.engine),
		.dev_clk_fall_i (dev_clk_fall),
		.dev_dat_i      (dev_dat),
		.ps2_clk_oe_o   (ps2_clk_oe_o),
		.ps2_dat_oe_o   (ps2_dat_oe_o),
		.tx_busy_o      (tx_busy)
	);

	ps2_bus_regs i_ps2_bus_regs (
		.clk     (clk),
		.reset   (reset),
		.cs_i    (cs_i),
		.we_i    (we_i),
		.addr_i  (addr_i),
		.be_i    (be_i),
		.wdata_i (wdata_i),
		.rdata_o (rdata_o),
		.ready_o (ready_o),
		.irq_o   (irq_o),
		.q       (i_rdq_if.reader),
		.cmd     (i_cmd_if.host)
	);

endmodule

//--- ps2_props.sv
// PS/2 port bound checks
module ps2_props (
	input logic               clk,
	input logic               reset,
	input logic               req_i,
	input logic               ack_i,
	input ps2_pkg::tx_state_t state_i,
	input logic               clk_oe_i,
	input logic               dat_oe_i,
	input logic               irq_i,
	input logic               re_i
);

	// Engine answers only an open request
	ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack_i) |-> req_i)
		else $error("ack rose without req");

	// Host keeps asking until answered
	req_until_ack: assert property (@(posedge clk) disable iff (reset)
		req_i && !ack_i |=> req_i)
		else $error("req dropped before ack");

	// Only the inhibit to start step swaps both lines
	oe_swap_at_start: assert property (@(posedge clk) disable iff (reset)
		$changed(clk_oe_i) && $changed(dat_oe_i) |-> state_i == ps2_pkg::TX_START)
		else $error("both oe outputs changed outside TX_START");

	// RI is registered, so RE one cycle back
	irq_needs_re: assert property (@(posedge clk) disable iff (reset) irq_i |-> $past(re_i))
		else $error("irq_o high without RE");

endmodule

bind ps2_port ps2_props i_ps2_props (
	.clk      (clk),
	.reset    (reset),
	.req_i    (i_cmd_if.req),
	.ack_i    (i_cmd_if.ack),
	.state_i  (i_ps2_cmd_tx.state),
	.clk_oe_i (ps2_clk_oe_o),
	.dat_oe_i (ps2_dat_oe_o),
	.irq_i    (irq_o),
	.re_i     (i_ps2_bus_regs.re_q)
);

//--- ps2_rx.sv
// PS/2 receive deframer
module ps2_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       ps2_clk_i,
	input  logic       ps2_dat_i,
	input  logic       tx_busy_i,
	output logic       dev_clk_fall_o,
	output logic       dev_dat_o,
	output logic       push_o,
	output logic [7:0] byte_o
);

	// Quiet-line timer width, about 650 us at 100 MHz
	localparam int QUIET_W = 16;

	logic [1:0]         clk_sync;
	logic [1:0]         dat_sync;
	logic               clk_last;
	logic [3:0]         bit_cnt;
	logic [QUIET_W-1:0] quiet_cnt;
	logic [10:0]        shift_q;
	logic [10:0]        frame_next;
	logic               frame_ok;

	// Falling edge seen after the synchronizer
	assign dev_clk_fall_o = clk_last & ~clk_sync[1];
	assign dev_dat_o      = dat_sync[1];

	// Bits arrive LSB first, so shift in at the top
	assign frame_next = {dev_dat_o, shift_q[10:1]};

	// Start low, odd parity over data and parity, stop high
	assign frame_ok = ~frame_next[0] & (^frame_next[9:1]) & frame_next[10];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// Idle lines float high
			clk_sync  <= 2'b11;
			dat_sync  <= 2'b11;
			clk_last  <= 1'b1;
			bit_cnt   <= '0;
			quiet_cnt <= '0;
			push_o    <= 1'b0;
		end
		else
		begin
			clk_sync <= {clk_sync[0], ps2_clk_i};
			dat_sync <= {dat_sync[0], ps2_dat_i};
			clk_last <= clk_sync[1];
			push_o   <= 1'b0;
			if (tx_busy_i)
			begin
				// Transmitter owns the lines, abandon any partial frame
				bit_cnt   <= '0;
				quiet_cnt <= '0;
			end
			else if (dev_clk_fall_o)
			begin
				quiet_cnt <= '0;
				if (bit_cnt == 4'd10)
				begin
					bit_cnt <= '0;
					push_o  <= frame_ok;
				end
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
			else if (bit_cnt != 4'd0)
			begin
				// Lost edge, resync on the next start bit
				if (&quiet_cnt)
					bit_cnt <= '0;
				quiet_cnt <= quiet_cnt + 1'b1;
			end
		end
	end

	// Frame shifter and byte holding register
	always_ff @(posedge clk)
	begin
		if (dev_clk_fall_o)
			shift_q <= frame_next;
		if (dev_clk_fall_o && bit_cnt == 4'd10)
			byte_o <= frame_next[8:1];
	end

endmodule

//--- ps2_rx_fifo.sv
// PS/2 receive queue
module ps2_rx_fifo #(
	parameter int DEPTH = 16
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      push_i,
	input  logic [7:0] din_i,
	ps2_rdq_if.queue  q
);

	localparam int AW = $clog2(DEPTH);

	logic [7:0]  mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_push;
	logic          do_pop;

	// Overflow drops the byte, underflow is a no-op
	assign do_push = push_i & ~q.full;
	assign do_pop  = q.pop & ~q.empty;

	assign q.empty = (count == '0);
	assign q.full  = (count == (AW + 1)'(DEPTH));
	assign q.count = count;
	// Showahead head
	assign q.data  = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// Pointers wrap on the power-of-two depth
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= din_i;
	end

endmodule

//--- ps2_tb.sv
// PS/2 port testbench
module ps2_tb;

	localparam int DEPTH = 4;
	// Device clock half period in system cycles
	localparam int HALF = 20;
	// Longer than the 15 ms start timeout
	localparam int CMD_LIMIT = 20000;

	logic        clk = 1'b0;
	logic        reset;
	logic        cs_i;
	logic        we_i;
	logic        addr_i;
	logic [3:0]  be_i;
	logic [31:0] wdata_i;
	logic [31:0] rdata_o;
	logic        ready_o;
	logic        irq_o;
	logic        ps2_clk_i;
	logic        ps2_dat_i;
	logic        ps2_clk_oe_o;
	logic        ps2_dat_oe_o;

	// Device side pull-downs
	logic        dev_clk_lo;
	logic        dev_dat_lo;

	// Model of queue contents and control bits
	logic [7:0]  model_q [$];
	logic        model_re;
	logic        model_ce;
	// Expected read words waiting for the compare process
	logic [31:0] exp_q [$];
	logic [31:0] mask_q [$];
	logic        rd_seen;
	logic        ready_q;
	logic        pass_shown;
	logic        fail_shown;
	int          waited;

	// Open-drain lines, low if either side pulls
	assign ps2_clk_i = ~(ps2_clk_oe_o | dev_clk_lo);
	assign ps2_dat_i = ~(ps2_dat_oe_o | dev_dat_lo);

	always #4 clk = ~clk;

	ps2_port #(
		.CLK_FREQ   (1_000_000),
		.FIFO_DEPTH (DEPTH)
	) i_ps2_port (
		.clk          (clk),
		.reset        (reset),
		.cs_i         (cs_i),
		.we_i         (we_i),
		.addr_i       (addr_i),
		.be_i         (be_i),
		.wdata_i      (wdata_i),
		.rdata_o      (rdata_o),
		.ready_o      (ready_o),
		.irq_o        (irq_o),
		.ps2_clk_i    (ps2_clk_i),
		.ps2_dat_i    (ps2_dat_i),
		.ps2_clk_oe_o (ps2_clk_oe_o),
		.ps2_dat_oe_o (ps2_dat_oe_o)
	);

	task automatic fail_stop(input string why);
		fail_shown = 1'b1;
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_stop($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	// Expected register word from the model state
	function automatic logic [31:0] expected_word(input ps2_pkg::reg_sel_t sel);
		logic [31:0] w;
		w = '0;
		if (sel == ps2_pkg::REG_CTRL)
		begin
			w[ps2_pkg::CTRL_RE_BIT] = model_re;
			w[ps2_pkg::CTRL_RI_BIT] = model_re && (model_q.size() != 0);
			w[ps2_pkg::CTRL_CE_BIT] = model_ce;
		end
		else
		begin
			w[ps2_pkg::DATA_COUNT_LSB +: 16] = 16'(model_q.size());
			if (model_q.size() != 0)
			begin
				w[ps2_pkg::DATA_VALID_BIT] = 1'b1;
				w[7:0]                     = model_q[0];
			end
		end
		return w;
	endfunction

	// Data, odd parity and stop as the device should sample them
	function automatic logic [9:0] host_bits(input logic [7:0] b);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++)
			if (b[i])
				ones++;
		return {1'b1, (ones % 2) == 0, b};
	endfunction

	// Registered view of ready_o and read accesses
	always @(posedge clk)
	begin
		ready_q <= ready_o;
		rd_seen <= cs_i & ~we_i;
	end

	// Compare read data one clock after the access
	always @(negedge clk)
	begin
		if (rd_seen)
		begin
			check("rdata_o", rdata_o & mask_q[0], exp_q[0] & mask_q[0]);
			void'(exp_q.pop_front());
			void'(mask_q.pop_front());
		end
	end

	task automatic read_reg(input ps2_pkg::reg_sel_t sel);
		cs_i   = 1'b1;
		we_i   = 1'b0;
		addr_i = sel;
		be_i   = 4'h1;
		exp_q.push_back(expected_word(sel));
		// Head byte is stale when the queue is empty
		if (sel == ps2_pkg::REG_DATA && model_q.size() == 0)
			mask_q.push_back(32'hFFFF_FF00);
		else
			mask_q.push_back(32'hFFFF_FFFF);
		if (sel == ps2_pkg::REG_DATA && model_q.size() != 0)
			void'(model_q.pop_front());
		@(negedge clk);
		cs_i = 1'b0;
		@(negedge clk);
	endtask

	task automatic bus_write(input ps2_pkg::reg_sel_t sel, input logic [3:0] be,
		input logic [31:0] data, output int cycles);
		int n;
		cs_i    = 1'b1;
		we_i    = 1'b1;
		addr_i  = sel;
		be_i    = be;
		wdata_i = data;
		n = 0;
		@(negedge clk);
		// Hold the access until ready_o was seen high
		while (!ready_q && n < CMD_LIMIT)
		begin
			n++;
			@(negedge clk);
		end
		if (!ready_q)
			fail_stop("bus write never completed, ready_o stayed low");
		cs_i = 1'b0;
		we_i = 1'b0;
		cycles = n;
		if (sel == ps2_pkg::REG_CTRL && be[0])
			model_re = data[0];
		if (sel == ps2_pkg::REG_CTRL && be[1])
			model_ce = 1'b0;
		@(negedge clk);
	endtask

	// Device to host frame
	task automatic send_byte(input logic [7:0] b, input logic bad);
		logic [10:0] f;
		f = {1'b1, (~^b) ^ bad, b, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			dev_dat_lo = ~f[i];
			repeat (HALF) @(negedge clk);
			dev_clk_lo = 1'b1;
			repeat (HALF) @(negedge clk);
			dev_clk_lo = 1'b0;
		end
		dev_dat_lo = 1'b0;
		repeat (HALF) @(negedge clk);
		// Bad frames and overflow are dropped
		if (!bad && model_q.size() < DEPTH)
			model_q.push_back(b);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq_o !== level && n < 200)
		begin
			n++;
			@(negedge clk);
		end
		if (irq_o !== level)
			fail_stop($sformatf("irq_o did not reach %0d in time", level));
	endtask

	// Host to device frame seen from the device
	task automatic host_frame(input logic [7:0] cmd, input logic give_ack, input logic silent);
		logic [9:0] got;
		int n;
		n = 0;
		while (!ps2_clk_oe_o && n < 100)
		begin
			n++;
			@(negedge clk);
		end
		if (!ps2_clk_oe_o)
			fail_stop("DUT never inhibited the clock line");
		n = 0;
		while (ps2_clk_oe_o && n < 1000)
		begin
			n++;
			@(negedge clk);
		end
		check("inhibit cycles", 32'(n), 32'd101);
		check("start bit ps2_dat_oe_o", 32'(ps2_dat_oe_o), 32'd1);
		if (!silent)
		begin
			for (int i = 0; i < 11; i++)
			begin
				repeat (HALF) @(negedge clk);
				// Acknowledge held low across the 11th fall
				if (i == 10 && give_ack)
					dev_dat_lo = 1'b1;
				dev_clk_lo = 1'b1;
				repeat (HALF) @(negedge clk);
				dev_clk_lo = 1'b0;
				if (i < 10)
					got[i] = ps2_dat_i;
			end
			repeat (HALF) @(negedge clk);
			dev_dat_lo = 1'b0;
			check("host frame bits", 32'(got), 32'(host_bits(cmd)));
		end
	endtask

	initial
	begin
		cs_i       = 1'b0;
		we_i       = 1'b0;
		addr_i     = 1'b0;
		be_i       = 4'h0;
		wdata_i    = '0;
		dev_clk_lo = 1'b0;
		dev_dat_lo = 1'b0;
		model_re   = 1'b0;
		model_ce   = 1'b0;
		rd_seen    = 1'b0;
		ready_q    = 1'b0;
		pass_shown = 1'b0;
		fail_shown = 1'b0;
		void'($urandom(41));
		reset = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check("ready_o after reset", 32'(ready_o), 32'd1);
		check("irq_o after reset", 32'(irq_o), 32'd0);
		read_reg(ps2_pkg::REG_DATA);
		read_reg(ps2_pkg::REG_CTRL);
		// Random bytes come back in order
		for (int i = 0; i < 3; i++)
			send_byte(8'($urandom()), 1'b0);
		for (int i = 0; i < 3; i++)
			read_reg(ps2_pkg::REG_DATA);
		// Bad parity frame leaves the queue alone
		send_byte(8'($urandom()), 1'b0);
		send_byte(8'($urandom()), 1'b1);
		read_reg(ps2_pkg::REG_DATA);
		read_reg(ps2_pkg::REG_DATA);
		// Overflow with six bytes into four slots
		for (int i = 0; i < 6; i++)
			send_byte(8'($urandom()), 1'b0);
		for (int i = 0; i < 5; i++)
			read_reg(ps2_pkg::REG_DATA);
		// Interrupt follows RE and queue occupancy
		bus_write(ps2_pkg::REG_CTRL, 4'h1, 32'd1, waited);
		send_byte(8'($urandom()), 1'b0);
		wait_irq(1'b1);
		read_reg(ps2_pkg::REG_CTRL);
		read_reg(ps2_pkg::REG_DATA);
		wait_irq(1'b0);
		bus_write(ps2_pkg::REG_CTRL, 4'h1, 32'd0, waited);
		send_byte(8'($urandom()), 1'b0);
		check("irq_o with RE clear", 32'(irq_o), 32'd0);
		read_reg(ps2_pkg::REG_CTRL);
		read_reg(ps2_pkg::REG_DATA);
		// Good command with acknowledge
		fork
			bus_write(ps2_pkg::REG_DATA, 4'h1, 32'h0000_00F4, waited);
			host_frame(8'hF4, 1'b1, 1'b0);
		join
		check("command stalled ready_o", 32'(waited > 101), 32'd1);
		read_reg(ps2_pkg::REG_CTRL);
		// Silent device times out
		fork
			bus_write(ps2_pkg::REG_DATA, 4'h1, 32'h0000_00FF, waited);
			host_frame(8'hFF, 1'b1, 1'b1);
		join
		model_ce = 1'b1;
		read_reg(ps2_pkg::REG_CTRL);
		bus_write(ps2_pkg::REG_CTRL, 4'h2, 32'd0, waited);
		read_reg(ps2_pkg::REG_CTRL);
		// Device never acknowledges
		fork
			bus_write(ps2_pkg::REG_DATA, 4'h1, 32'h0000_00ED, waited);
			host_frame(8'hED, 1'b0, 1'b0);
		join
		model_ce = 1'b1;
		read_reg(ps2_pkg::REG_CTRL);
		bus_write(ps2_pkg::REG_CTRL, 4'h2, 32'd0, waited);
		read_reg(ps2_pkg::REG_CTRL);
		@(negedge clk);
		pass_shown = 1'b1;
		$display("SIMULATION PASSED");
		$finish;
	end

	// Run ended by an assertion or the simulator
	final
	begin
		if (!pass_shown && !fail_shown)
			$display("SIMULATION FAILED");
	end

endmodule
